/* tb.f */
+incdir+hdl
hdl/patch_match_pkg.sv
hdl/patch_rd_if.sv
hdl/sram_1kbyte_1rw1r.sv
hdl/patch_mem.sv
hdl/patch_sad_engine.sv
hdl/patch_match_top.sv
tests/tb_patch_match.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_patch_match -f tb.f -o sim_tb_patch_match

# The exit status of the pipeline is the one of tee, the log decides
./obj_dir/sim_tb_patch_match | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tests/tb_patch_match.sv */
`timescale 1ns/1ps
`include "patch_match_config.svh"

module tb_patch_match;
    import patch_match_pkg::*;

    typedef logic [`PM_ADDR_WIDTH:0] count_t;

    localparam int ACK_TIMEOUT  = 16;
    localparam int DONE_TIMEOUT = 2000;
    localparam int GATE_CYCLES  = 20;    // Cycles to wait for an ack that must not come
    localparam int LOAD_CNT     = 8;     // Keys reloaded per case
    localparam int TIE_LO       = 2;
    localparam int TIE_HI       = 5;

    // Load paths
    localparam int PATH_DIRECT = 0;
    localparam int PATH_WB     = 1;
    localparam int PATH_TIE    = 2;

    // Each case holds query index, key count and load path
    localparam int N_CASES = 8;
    localparam int CASE_QIDX  [N_CASES] = '{5, 17, 9, 100, 200, 0, 511, 42};
    localparam int CASE_NKEYS [N_CASES] = '{16, 16, 12, 1, 512, 0, 512, 40};
    localparam int CASE_PATH  [N_CASES] = '{
        PATH_DIRECT, PATH_WB, PATH_TIE, PATH_DIRECT,
        PATH_WB, PATH_DIRECT, PATH_DIRECT, PATH_WB
    };

    logic        clk = 1'b0;
    logic        reset_i;
    logic        wb_mode_i;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic        wbs_ack_o;
    logic [31:0] wbs_dat_o;
    logic        patch_wr_en_i;
    logic        patch_wr_bank_i;
    addr_t       patch_wr_addr_i;
    patch_t      patch_wr_patch_i;
    logic        start_i;
    addr_t       query_idx_i;
    count_t      num_keys_i;
    logic        busy_o;
    logic        done_o;
    addr_t       best_idx_o;
    dist_t       best_dist_o;

    int     seed = 35500;
    patch_t query_model [`PM_DEPTH];    // Reference copies of both memories
    patch_t key_model [`PM_DEPTH];

    always #10 clk = ~clk;

    patch_match_top u_patch_match_top (
        .clk (clk), .reset_i (reset_i), .wb_mode_i (wb_mode_i),
        .wbs_cyc_i (wbs_cyc_i), .wbs_stb_i (wbs_stb_i), .wbs_we_i (wbs_we_i),
        .wbs_adr_i (wbs_adr_i), .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o), .wbs_dat_o (wbs_dat_o),
        .patch_wr_en_i (patch_wr_en_i), .patch_wr_bank_i (patch_wr_bank_i),
        .patch_wr_addr_i (patch_wr_addr_i), .patch_wr_patch_i (patch_wr_patch_i),
        .start_i (start_i), .query_idx_i (query_idx_i), .num_keys_i (num_keys_i),
        .busy_o (busy_o), .done_o (done_o),
        .best_idx_o (best_idx_o), .best_dist_o (best_dist_o)
    );

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail at time %0t: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    function automatic patch_t random_patch();
        patch_t p;
        for (int i = 0; i < `PM_PATCH_SIZE; i++) begin
            p[i] = pixel_t'($random(seed));
        end
        return p;
    endfunction

    function automatic int patch_sad(input patch_t a, input patch_t b);
        int sum;
        sum = 0;
        for (int i = 0; i < `PM_PATCH_SIZE; i++) begin
            sum += (a[i] > b[i]) ? int'(a[i]) - int'(b[i]) : int'(b[i]) - int'(a[i]);
        end
        return sum;
    endfunction

    task automatic wait_ack(input int limit, output bit seen);
        seen = 1'b0;
        for (int t = 0; t < limit && !seen; t++) begin
            @(negedge clk);
            seen = wbs_ack_o;
        end
    endtask

    // One classic single transfer held until ack
    task automatic wb_transfer(input logic we, input logic [31:0] adr,
                               input logic [31:0] dat, output logic [31:0] rdata);
        bit seen;
        @(posedge clk);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= adr;
        wbs_dat_i <= dat;
        wait_ack(ACK_TIMEOUT, seen);
        if (!seen) fail_stop("Wishbone transfer got no ack before the timeout");
        rdata = wbs_dat_o;
        @(posedge clk);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic direct_write(input logic bank, input int idx, input patch_t p);
        @(posedge clk);
        patch_wr_en_i    <= 1'b1;
        patch_wr_bank_i  <= bank;
        patch_wr_addr_i  <= addr_t'(idx);
        patch_wr_patch_i <= p;
        @(posedge clk);
        patch_wr_en_i <= 1'b0;
    endtask

    // Eight byte lanes are written and both halves read back
    task automatic key_load_wb(input int idx);
        logic [63:0] row;
        logic [31:0] base;
        logic [31:0] rdata;
        row  = 64'(key_model[idx]);
        base = `PM_KEY_WB_BASE + (32'(idx) << 3);
        for (int lane = 0; lane < 8; lane++) begin
            wb_transfer(1'b1, base, {18'd0, 3'(lane), 3'd0, row[lane*8 +: 8]}, rdata);
        end
        wb_transfer(1'b0, base, 32'd0, rdata);
        check_value("wbs_dat_o low half", 64'(rdata), 64'(row[31:0]));
        wb_transfer(1'b0, base + 32'd4, 32'd0, rdata);
        check_value("wbs_dat_o high half", 64'(rdata), 64'(row[54:32]));
    endtask

    task automatic check_mode_gating();
        bit seen;
        @(posedge clk);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= 1'b1;
        wbs_adr_i <= `PM_KEY_WB_BASE;
        wbs_dat_i <= 32'h0000_005A;
        wait_ack(GATE_CYCLES, seen);
        if (seen) fail_stop("Wishbone request was acked while wb_mode_i was low");
        @(posedge clk);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic load_case(input int qidx, input int path);
        query_model[qidx] = random_patch();
        direct_write(1'b0, qidx, query_model[qidx]);
        for (int k = 0; k < LOAD_CNT; k++) begin
            key_model[k] = random_patch();
        end
        if (path == PATH_TIE) begin
            key_model[TIE_LO] = query_model[qidx];  // Two exact matches
            key_model[TIE_HI] = query_model[qidx];
        end
        if (path == PATH_WB) begin
            @(posedge clk);
            wb_mode_i <= 1'b1;
            for (int k = 0; k < LOAD_CNT; k++) key_load_wb(k);
            @(posedge clk);
            wb_mode_i <= 1'b0;
        end else begin
            for (int k = 0; k < LOAD_CNT; k++) direct_write(1'b1, k, key_model[k]);
        end
    endtask

    task automatic run_scan(input int qidx, input int nkeys);
        int exp_dist;
        int exp_idx;
        int d;
        bit seen;
        exp_dist = (1 << `PM_DIST_WIDTH) - 1;
        exp_idx  = 0;
        for (int k = 0; k < nkeys; k++) begin
            d = patch_sad(query_model[qidx], key_model[k]);
            if (d < exp_dist) begin     // Ties keep the lower index
                exp_dist = d;
                exp_idx  = k;
            end
        end
        @(posedge clk);
        start_i     <= 1'b1;
        query_idx_i <= addr_t'(qidx);
        num_keys_i  <= count_t'(nkeys);
        @(posedge clk);
        start_i <= 1'b0;
        seen = 1'b0;
        for (int t = 0; t < DONE_TIMEOUT && !seen; t++) begin
            @(negedge clk);
            seen = done_o;
        end
        if (!seen) fail_stop("Scan did not finish before the timeout");
        check_value("best_idx_o", 64'(best_idx_o), 64'(exp_idx));
        check_value("best_dist_o", 64'(best_dist_o), 64'(exp_dist));
    endtask

    initial begin
        reset_i          = 1'b1;
        wb_mode_i        = 1'b0;
        wbs_cyc_i        = 1'b0;
        wbs_stb_i        = 1'b0;
        wbs_we_i         = 1'b0;
        wbs_adr_i        = '0;
        wbs_dat_i        = '0;
        patch_wr_en_i    = 1'b0;
        patch_wr_bank_i  = 1'b0;
        patch_wr_addr_i  = '0;
        patch_wr_patch_i = '0;
        start_i          = 1'b0;
        query_idx_i      = '0;
        num_keys_i       = '0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("busy_o", 64'(busy_o), 64'd0);
        check_value("done_o", 64'(done_o), 64'd0);
        check_value("wbs_ack_o", 64'(wbs_ack_o), 64'd0);
        check_value("best_dist_o", 64'(best_dist_o), 64'((1 << `PM_DIST_WIDTH) - 1));
        check_mode_gating();

        // Fill both memories so full-depth scans read known rows
        for (int i = 0; i < `PM_DEPTH; i++) begin
            query_model[i] = random_patch();
            key_model[i]   = random_patch();
            direct_write(1'b0, i, query_model[i]);
            direct_write(1'b1, i, key_model[i]);
        end

        for (int c = 0; c < N_CASES; c++) begin
            load_case(CASE_QIDX[c], CASE_PATH[c]);
            run_scan(CASE_QIDX[c], CASE_NKEYS[c]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* hdl/patch_match_top.sv */
`timescale 1ns/1ps
`include "patch_match_config.svh"

module patch_match_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    wb_mode_i,
    // Wishbone slave, shared by both memories
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_stb_i,
    input  logic                    wbs_we_i,
    input  logic [31:0]             wbs_adr_i,
    input  logic [31:0]             wbs_dat_i,
    output logic                    wbs_ack_o,
    output logic [31:0]             wbs_dat_o,
    // Direct patch write, bank 0 query and bank 1 key
    input  logic                    patch_wr_en_i,
    input  logic                    patch_wr_bank_i,
    input  patch_match_pkg::addr_t  patch_wr_addr_i,
    input  patch_match_pkg::patch_t patch_wr_patch_i,
    // Matching engine
    input  logic                    start_i,
    input  patch_match_pkg::addr_t  query_idx_i,
    input  logic [`PM_ADDR_WIDTH:0] num_keys_i,
    output logic                    busy_o,
    output logic                    done_o,
    output patch_match_pkg::addr_t  best_idx_o,
    output patch_match_pkg::dist_t  best_dist_o
);

    logic        query_ack;
    logic        key_ack;
    logic [31:0] query_dat;
    logic [31:0] key_dat;

    patch_rd_if query_rd_bus ();
    patch_rd_if key_rd_bus ();

    // Non-owning memory drives zeros
    assign wbs_ack_o = query_ack | key_ack;
    assign wbs_dat_o = query_dat | key_dat;

    patch_mem #(
        .BANK_ID (1'b0),
        .WB_BASE (`PM_QUERY_WB_BASE)
    ) u_query_mem (
        .clk              (clk),
        .reset_i          (reset_i),
        .wb_mode_i        (wb_mode_i),
        .wbs_cyc_i        (wbs_cyc_i),
        .wbs_stb_i        (wbs_stb_i),
        .wbs_we_i         (wbs_we_i),
        .wbs_adr_i        (wbs_adr_i),
        .wbs_dat_i        (wbs_dat_i),
        .wbs_ack_o        (query_ack),
        .wbs_dat_o        (query_dat),
        .patch_wr_en_i    (patch_wr_en_i),
        .patch_wr_bank_i  (patch_wr_bank_i),
        .patch_wr_addr_i  (patch_wr_addr_i),
        .patch_wr_patch_i (patch_wr_patch_i),
        .rd               (query_rd_bus.memory)
    );

    patch_mem #(
        .BANK_ID (1'b1),
        .WB_BASE (`PM_KEY_WB_BASE)
    ) u_key_mem (
        .clk              (clk),
        .reset_i          (reset_i),
        .wb_mode_i        (wb_mode_i),
        .wbs_cyc_i        (wbs_cyc_i),
        .wbs_stb_i        (wbs_stb_i),
        .wbs_we_i         (wbs_we_i),
        .wbs_adr_i        (wbs_adr_i),
        .wbs_dat_i        (wbs_dat_i),
        .wbs_ack_o        (key_ack),
        .wbs_dat_o        (key_dat),
        .patch_wr_en_i    (patch_wr_en_i),
        .patch_wr_bank_i  (patch_wr_bank_i),
        .patch_wr_addr_i  (patch_wr_addr_i),
        .patch_wr_patch_i (patch_wr_patch_i),
        .rd               (key_rd_bus.memory)
    );

    patch_sad_engine u_engine (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .query_idx_i (query_idx_i),
        .num_keys_i  (num_keys_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .best_idx_o  (best_idx_o),
        .best_dist_o (best_dist_o),
        .query_rd    (query_rd_bus.requester),
        .key_rd      (key_rd_bus.requester)
    );

endmodule

/* hdl/patch_sad_engine.sv */
`timescale 1ns/1ps
`include "patch_match_config.svh"

module patch_sad_engine (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  patch_match_pkg::addr_t  query_idx_i,
    input  logic [`PM_ADDR_WIDTH:0] num_keys_i,
    output logic                    busy_o,
    output logic                    done_o,
    output patch_match_pkg::addr_t  best_idx_o,
    output patch_match_pkg::dist_t  best_dist_o,
    patch_rd_if.requester           query_rd,
    patch_rd_if.requester           key_rd
);
    import patch_match_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_QUERY,
        S_SCAN,
        S_DRAIN
    } state_t;

    state_t state;

    addr_t  q_idx;
    addr_t  last_idx;   // num_keys - 1
    addr_t  key_cnt;    // Next key to request
    patch_t query_q;

    // Stage 1, tag of the read in flight
    addr_t  s1_idx;
    logic   s1_last;

    // Stage 2, SAD result waiting for compare
    logic   s2_valid;
    addr_t  s2_idx;
    dist_t  s2_dist;
    logic   s2_last;

    dist_t  sad_sum;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    assign busy_o = (state != S_IDLE);

    // Query read once, then one key address per cycle
    assign query_rd.rd_en   = (state == S_QUERY);
    assign query_rd.rd_addr = q_idx;
    assign key_rd.rd_en     = (state == S_SCAN);
    assign key_rd.rd_addr   = key_cnt;

    // SAD of the returning key against the held query
    always_comb begin
        sad_sum = '0;
        for (int p = 0; p < `PM_PATCH_SIZE; p++) begin
            sad_sum = sad_sum + dist_t'(abs_diff(query_q[p], key_rd.rd_patch[p]));
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= S_IDLE;
            done_o      <= 1'b0;
            s2_valid    <= 1'b0;
            best_idx_o  <= '0;
            best_dist_o <= '1;
        end else begin
            done_o   <= 1'b0;
            s2_valid <= key_rd.rd_valid;

            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        best_idx_o  <= '0;
                        best_dist_o <= '1;
                        if (num_keys_i == '0) begin
                            done_o <= 1'b1; // Nothing to scan
                        end else begin
                            state <= S_QUERY;
                        end
                    end
                end
                S_QUERY: state <= S_SCAN;
                S_SCAN: begin
                    if (key_cnt == last_idx) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (s2_valid && s2_last) begin
                        state  <= S_IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase

            // Strictly smaller only, so ties keep the lower index
            if (s2_valid && (s2_dist < best_dist_o)) begin
                best_dist_o <= s2_dist;
                best_idx_o  <= s2_idx;
            end
        end
    end

    // Datapath and tags
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && start_i) begin
            q_idx    <= query_idx_i;
            last_idx <= addr_t'(num_keys_i - 1'b1);
        end

        if (state == S_QUERY) begin
            key_cnt <= '0;
        end else if (key_rd.rd_en) begin
            key_cnt <= key_cnt + 1'b1;
        end

        if (query_rd.rd_valid) begin
            query_q <= query_rd.rd_patch;
        end

        if (key_rd.rd_en) begin
            s1_idx  <= key_cnt;
            s1_last <= (key_cnt == last_idx);
        end

        s2_idx  <= s1_idx;
        s2_dist <= sad_sum;
        s2_last <= s1_last;
    end

    // A new scan must wait for the previous one
    a_start_idle: assert property (
        @(posedge clk) disable iff (reset_i) busy_o |-> !start_i
    );

endmodule

/* hdl/patch_mem.sv */
`timescale 1ns/1ps
`include "patch_match_config.svh"

module patch_mem #(
    parameter bit          BANK_ID = 1'b0,
    parameter logic [31:0] WB_BASE = `PM_QUERY_WB_BASE
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    wb_mode_i,
    // Wishbone slave
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_stb_i,
    input  logic                    wbs_we_i,
    input  logic [31:0]             wbs_adr_i,
    input  logic [31:0]             wbs_dat_i,
    output logic                    wbs_ack_o,
    output logic [31:0]             wbs_dat_o,
    // Direct full-patch write
    input  logic                    patch_wr_en_i,
    input  logic                    patch_wr_bank_i,
    input  patch_match_pkg::addr_t  patch_wr_addr_i,
    input  patch_match_pkg::patch_t patch_wr_patch_i,
    // Engine read port
    patch_rd_if.memory              rd
);
    import patch_match_pkg::*;

    localparam int PATCH_BITS = $bits(patch_t);
    localparam logic [31:0] WB_SPAN = 32'(`PM_DEPTH * 8);

    logic [31:0] wb_offset;
    logic        wb_hit;
    logic        wb_req;
    logic [2:0]  lane;
    logic [7:0]  wb_mask;
    row_t        wb_wdata;
    logic        direct_wr;

    logic        ram_csb0;
    logic        ram_web0;
    logic [7:0]  ram_wmask;
    addr_t       ram_addr0;
    row_t        ram_din0;
    row_t        ram_dout0;
    row_t        ram_dout1;

    logic        rd_ack_q;  // Current ack belongs to a read
    logic        half_q;    // Address bit 2 of that read
    logic [31:0] wb_rd_word;

    // Addresses below the base wrap to a large offset and miss the window
    assign wb_offset = wbs_adr_i - WB_BASE;
    assign wb_hit    = wb_offset < WB_SPAN;

    // No new request in the ack cycle while the master still holds stb
    assign wb_req = wb_mode_i && wbs_cyc_i && wbs_stb_i && wb_hit && !wbs_ack_o;

    // Byte lane picked by data bits 13:11
    assign lane     = wbs_dat_i[13:11];
    assign wb_mask  = 8'b1 << lane;
    assign wb_wdata = {{(`PM_ROW_WIDTH - 8){1'b0}}, wbs_dat_i[7:0]} << {lane, 3'b000};

    assign direct_wr = !wb_mode_i && patch_wr_en_i && (patch_wr_bank_i == BANK_ID);

    // Port 0 shared between Wishbone and direct writes
    assign ram_csb0  = !(wb_req || direct_wr);
    assign ram_web0  = wb_mode_i ? !wbs_we_i : 1'b0;
    assign ram_wmask = wb_mode_i ? wb_mask : 8'hFF;
    assign ram_addr0 = wb_mode_i ? wb_offset[3 +: `PM_ADDR_WIDTH] : patch_wr_addr_i;
    assign ram_din0  = wb_mode_i ? wb_wdata
                                 : {{(`PM_ROW_WIDTH - PATCH_BITS){1'b0}}, patch_wr_patch_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wbs_ack_o <= 1'b0;
            rd_ack_q  <= 1'b0;
        end else begin
            wbs_ack_o <= wb_req;
            rd_ack_q  <= wb_req && !wbs_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            half_q <= wbs_adr_i[2];
        end
    end

    // Low word, or patch bits 54:32 zero-extended
    assign wb_rd_word = half_q ? 32'(ram_dout0[PATCH_BITS-1:32]) : ram_dout0[31:0];
    assign wbs_dat_o  = rd_ack_q ? wb_rd_word : '0;

    // Engine side uses port 1 only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= rd.rd_en;
        end
    end

    assign rd.rd_patch = ram_dout1[PATCH_BITS-1:0];

    sram_1kbyte_1rw1r u_sram (
        .clk      (clk),
        .csb0_i   (ram_csb0),
        .web0_i   (ram_web0),
        .wmask0_i (ram_wmask),
        .addr0_i  (ram_addr0),
        .din0_i   (ram_din0),
        .dout0_o  (ram_dout0),
        .csb1_i   (!rd.rd_en),
        .addr1_i  (rd.rd_addr),
        .dout1_o  (ram_dout1)
    );

    // The master holds the request into the ack cycle
    a_req_held: assert property (
        @(posedge clk) disable iff (reset_i) wb_req |=> (wbs_cyc_i && wbs_stb_i)
    );

    // Address and direction stay put until the ack
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset_i)
            wb_req |=> ($stable(wbs_adr_i) && $stable(wbs_we_i))
    );

endmodule

/* hdl/sram_1kbyte_1rw1r.sv */
`timescale 1ns/1ps
`include "patch_match_config.svh"

module sram_1kbyte_1rw1r (
    input  logic                   clk,
    // Port 0 reads or writes with a byte mask
    input  logic                   csb0_i,      // Active low
    input  logic                   web0_i,      // Active low
    input  logic [7:0]             wmask0_i,
    input  patch_match_pkg::addr_t addr0_i,
    input  patch_match_pkg::row_t  din0_i,
    output patch_match_pkg::row_t  dout0_o,
    // Port 1 only reads
    input  logic                   csb1_i,      // Active low
    input  patch_match_pkg::addr_t addr1_i,
    output patch_match_pkg::row_t  dout1_o
);
    import patch_match_pkg::*;

    row_t mem [`PM_DEPTH];

    // Port 0
    always_ff @(posedge clk) begin
        if (!csb0_i) begin
            if (!web0_i) begin
                for (int b = 0; b < 8; b++) begin
                    if (wmask0_i[b]) begin
                        mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
                    end
                end
            end else begin
                dout0_o <= mem[addr0_i]; // Output only changes on a read
            end
        end
    end

    // Port 1
    always_ff @(posedge clk) begin
        if (!csb1_i) begin
            dout1_o <= mem[addr1_i];
        end
    end

    // Port 1 must not read the row that port 0 is writing
    a_rw_collision: assert property (
        @(posedge clk) (!csb0_i && !web0_i && !csb1_i) |-> (addr0_i != addr1_i)
    );

endmodule

/* hdl/patch_rd_if.sv */
`timescale 1ns/1ps

// Single patch read port, data one cycle after rd_en
interface patch_rd_if;
    import patch_match_pkg::*;

    logic   rd_en;
    addr_t  rd_addr;
    patch_t rd_patch;
    logic   rd_valid;

    modport requester (
        output rd_en,
        output rd_addr,
        input  rd_patch,
        input  rd_valid
    );

    modport memory (
        input  rd_en,
        input  rd_addr,
        output rd_patch,
        output rd_valid
    );

endinterface

/* hdl/patch_match_pkg.sv */
`include "patch_match_config.svh"

package patch_match_pkg;

    // One pixel of a patch
    typedef logic [`PM_PIXEL_WIDTH-1:0] pixel_t;

    // Pixel 0 sits in the low bits
    typedef pixel_t [`PM_PATCH_SIZE-1:0] patch_t;

    // One SRAM row, patch in the low 55 bits
    typedef logic [`PM_ROW_WIDTH-1:0] row_t;

    // Patch index inside one memory
    typedef logic [`PM_ADDR_WIDTH-1:0] addr_t;

    // Sum of absolute differences over one patch
    typedef logic [`PM_DIST_WIDTH-1:0] dist_t;

endpackage

/* hdl/patch_match_config.svh */
`ifndef PATCH_MATCH_CONFIG_SVH
`define PATCH_MATCH_CONFIG_SVH

// Patch geometry
`define PM_PIXEL_WIDTH 11
`define PM_PATCH_SIZE 5
`define PM_ADDR_WIDTH 9
`define PM_DEPTH 512

// SRAM row and SAD accumulator widths
`define PM_ROW_WIDTH 64
`define PM_DIST_WIDTH 14

// Wishbone byte windows, PM_DEPTH x 8 bytes each
`define PM_QUERY_WB_BASE 32'h3000_0000
`define PM_KEY_WB_BASE 32'h3000_1000

`endif
